// ==== Bender.yml ====
package:
  name: data_mem

sources:
  # RTL in compile order
  - logic/lsu_mem_pkg.sv
  - logic/apb_access_port.sv
  - logic/lane_steer.sv
  - logic/byte_bank.sv
  - logic/load_align.sv
  - logic/data_mem_top.sv

  # Testbench
  - target: test
    files:
      - test/data_mem_tb.sv

// ==== logic/apb_access_port.sv ====
// APB slave with no PSTRB or PPROT. Width and sign bit ride in paddr above the byte address

`timescale 1ns/1ns

module apb_access_port
  import lsu_mem_pkg::*;
#(
  parameter int mem_bytes = 4096,
  localparam int addr_bits = $clog2(mem_bytes)
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [addr_bits+2:0]   paddr,
  input  logic [31:0]            pwdata,
  output logic [31:0]            prdata,
  output logic                   pready,
  output logic                   pslverr,
  output logic                   req_valid,
  output mem_req_t               req,
  output logic [addr_bits-3:0]   word_index,
  input  logic                   misaligned,
  input  logic [31:0]            load_data
);

  logic access_phase;
  logic read_pending;

  // ########################################
  // Address split
  // ########################################

  assign req.byte_offset = paddr[1:0];
  assign req.width       = access_width_e'(paddr[addr_bits+1:addr_bits]);
  assign req.sign_ext    = paddr[addr_bits+2];
  assign req.write       = pwrite;
  assign req.wdata       = pwdata;
  assign word_index      = paddr[addr_bits-1:2];

  // ########################################
  // Strobe and wait state
  // ########################################

  assign access_phase = psel && penable;

  // First access cycle only, the second read cycle is the wait state
  assign req_valid = access_phase && !read_pending;

  always_ff @(posedge clk) begin
    if (rst) begin
      read_pending <= 1'b0;
    end else if (read_pending && access_phase) begin
      read_pending <= 1'b0;
    end else if (req_valid && !pwrite && !misaligned) begin
      read_pending <= 1'b1;
    end
  end

  // Writes and errors finish at once, good reads one cycle later
  assign pready  = read_pending || (req_valid && (pwrite || misaligned));
  assign pslverr = req_valid && misaligned;
  assign prdata  = read_pending ? load_data : 32'h0;

  // ########################################
  // Checks
  // ########################################

  // Each transfer ends with pready within two cycles while the master still holds it
  assert property (@(posedge clk) disable iff (rst)
                   req_valid |-> ##[0:2] (pready && access_phase));

  assert property (@(posedge clk) disable iff (rst) penable |-> psel);

endmodule

// ==== logic/byte_bank.sv ====
// Single-port byte RAM with registered read. Contents are not reset and start unknown

`timescale 1ns/1ns

module byte_bank #(
  parameter int depth = 1024,
  localparam int index_bits = $clog2(depth)
) (
  input  logic                  clk,
  input  logic                  en,
  input  logic                  we,
  input  logic [index_bits-1:0] index,
  input  logic [7:0]            wdata,
  output logic [7:0]            rdata
);

  logic [7:0] ram [depth];

  // ########################################
  // Write and read port
  // ########################################

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        ram[index] <= wdata;
      end
      // Old contents on a write, the port never reads back a store
      rdata <= ram[index];
    end
  end

endmodule

// ==== logic/data_mem_top.sv ====
// APB data memory, sized by mem_bytes which must be a power of two and at least 8

`timescale 1ns/1ns

module data_mem_top
  import lsu_mem_pkg::*;
#(
  parameter int mem_bytes = 4096,
  localparam int addr_bits = $clog2(mem_bytes)
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [addr_bits+2:0] paddr,
  input  logic [31:0]          pwdata,
  output logic [31:0]          prdata,
  output logic                 pready,
  output logic                 pslverr
);

  logic                       req_valid;
  mem_req_t                   req;
  logic [addr_bits-3:0]       word_index;
  logic [addr_bits-3:0]       bank_index;
  logic                       misaligned;
  lane_req_t                  lanes;
  load_ctl_t                  load_ctl;
  logic [lane_count-1:0][7:0] lane_rdata;
  logic [31:0]                load_data;

  apb_access_port #(
    .mem_bytes(mem_bytes)
  ) apb_access_port_inst (
    .clk, .rst,
    .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr,
    .req_valid, .req, .word_index,
    .misaligned, .load_data
  );

  lane_steer #(
    .mem_bytes(mem_bytes)
  ) lane_steer_inst (
    .clk, .rst,
    .req_valid, .req, .word_index,
    .lanes, .bank_index, .misaligned, .load_ctl
  );

  // ########################################
  // Byte lanes
  // ########################################

  for (genvar lane = 0; lane < lane_count; lane++) begin : g_lane
    byte_bank #(
      .depth(mem_bytes / lane_count)
    ) byte_bank_inst (
      .clk   (clk),
      .en    (lanes.lane_en[lane]),
      .we    (lanes.lane_we[lane]),
      .index (bank_index),
      .wdata (lanes.lane_data[lane]),
      .rdata (lane_rdata[lane])
    );
  end

  load_align load_align_inst (
    .lane_rdata, .load_ctl, .load_data
  );

endmodule

// ==== logic/lane_steer.sv ====
// Misaligned and reserved accesses enable no lane, so they never touch the banks

`timescale 1ns/1ns

module lane_steer
  import lsu_mem_pkg::*;
#(
  parameter int mem_bytes = 4096,
  localparam int addr_bits = $clog2(mem_bytes)
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req_valid,
  input  mem_req_t             req,
  input  logic [addr_bits-3:0] word_index,
  output lane_req_t            lanes,
  output logic [addr_bits-3:0] bank_index,
  output logic                 misaligned,
  output load_ctl_t            load_ctl
);

  logic [lane_count-1:0] lane_mask;

  // Alignment check and lane mask per width
  always_comb begin
    misaligned = 1'b0;
    lane_mask  = '0;
    case (req.width)
      byte_access: lane_mask = 4'b0001 << req.byte_offset;
      half_access: begin
        misaligned = req.byte_offset[0];
        lane_mask  = req.byte_offset[1] ? 4'b1100 : 4'b0011;
      end
      word_access: begin
        misaligned = (req.byte_offset != 2'b00);
        lane_mask  = 4'b1111;
      end
      default: misaligned = 1'b1;
    endcase
  end

  assign lanes.lane_en = (req_valid && !misaligned) ? lane_mask : '0;
  assign lanes.lane_we = lanes.lane_en & {lane_count{req.write}};

  // Store data replicated so each enabled lane sees its own byte
  always_comb begin
    case (req.width)
      byte_access: lanes.lane_data = {4{req.wdata[7:0]}};
      half_access: lanes.lane_data = {2{req.wdata[15:0]}};
      default:     lanes.lane_data = req.wdata;
    endcase
  end

  assign bank_index = word_index;

  // Decode info follows the bank read by one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      load_ctl <= '0;
    end else if (req_valid && !req.write) begin
      load_ctl.byte_offset <= req.byte_offset;
      load_ctl.width       <= req.width;
      load_ctl.sign_ext    <= req.sign_ext;
    end
  end

  // Odd halfwords, unaligned words and the reserved code are flagged and write no lane
  assert property (@(posedge clk) disable iff (rst)
                   ((req.width == half_access && req.byte_offset[0]) ||
                    (req.width == word_access && req.byte_offset != 2'b00) ||
                    req.width == reserved_access)
                   |-> misaligned && (lanes.lane_we == '0));

endmodule

// ==== logic/load_align.sv ====
// Picks and extends the loaded value. The reserved width returns zero

`timescale 1ns/1ns

module load_align
  import lsu_mem_pkg::*;
(
  input  logic [lane_count-1:0][7:0] lane_rdata,
  input  load_ctl_t                  load_ctl,
  output logic [31:0]                load_data
);

  mem_word_u  word;
  logic [7:0]  sel_byte;
  logic [15:0] sel_half;
  logic        fill;

  assign word.bytes = lane_rdata;

  // Both views read from the same word
  assign sel_byte = word.bytes[load_ctl.byte_offset];
  assign sel_half = word.halves[load_ctl.byte_offset[1]];

  always_comb begin
    fill = 1'b0;
    case (load_ctl.width)
      byte_access: begin
        fill      = load_ctl.sign_ext && sel_byte[7];
        load_data = {{24{fill}}, sel_byte};
      end
      half_access: begin
        fill      = load_ctl.sign_ext && sel_half[15];
        load_data = {{16{fill}}, sel_half};
      end
      word_access: load_data = word;
      default:     load_data = 32'h0;
    endcase
  end

endmodule

// ==== logic/lsu_mem_pkg.sv ====
// Shared types for the APB data memory. The lane count is fixed at four for a 32-bit data word

package lsu_mem_pkg;

  // ########################################
  // Sizes
  // ########################################

  // One byte lane per byte of the 32-bit data word
  localparam int lane_count = 4;

  // ########################################
  // Access width code
  // ########################################

  // Taken from the two paddr bits just above the byte address
  typedef enum logic [1:0] {
    byte_access     = 2'b00,
    half_access     = 2'b01,
    word_access     = 2'b10,
    reserved_access = 2'b11
  } access_width_e;

  // ########################################
  // Request and lane structs
  // ########################################

  // Request from the APB port to the steering block
  // The word index travels separately since its width follows mem_bytes
  typedef struct packed {
    logic [1:0]    byte_offset;
    access_width_e width;
    logic          sign_ext;
    logic          write;
    logic [31:0]   wdata;
  } mem_req_t;

  // Per-lane controls and store bytes, lane 0 is the lowest byte
  typedef struct packed {
    logic [lane_count-1:0]      lane_en;
    logic [lane_count-1:0]      lane_we;
    logic [lane_count-1:0][7:0] lane_data;
  } lane_req_t;

  // Load decode info, registered with the bank read
  typedef struct packed {
    logic [1:0]    byte_offset;
    access_width_e width;
    logic          sign_ext;
  } load_ctl_t;

  // ########################################
  // Returned data word
  // ########################################

  // Same 32 bits seen as bytes or as halfwords
  typedef union packed {
    logic [lane_count-1:0][7:0] bytes;
    logic [1:0][15:0]           halves;
  } mem_word_u;

endpackage

// ==== sim.f ====
logic/lsu_mem_pkg.sv
logic/apb_access_port.sv
logic/lane_steer.sv
logic/byte_bank.sv
logic/load_align.sv
logic/data_mem_top.sv
test/data_mem_tb.sv

// ==== test/data_mem_tb.sv ====
// Runs data_mem_top with mem_bytes of 256, so paddr is 11 bits. The memory is filled before any read

`timescale 1ns/1ns

module data_mem_tb
  import lsu_mem_pkg::*;
();

  localparam int clk_period   = 40;
  localparam int mem_bytes    = 256;
  localparam int random_count = 300;
  // Fill, a bound on the directed transfers, and the random mix
  localparam int transfer_total = mem_bytes / 4 + 40 + random_count;

  logic        clk;
  logic        rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [10:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  // Expectations for the transfer in flight, set with the access phase
  logic        first_cycle;
  logic        exp_err;
  logic        exp_first_ready;
  logic [31:0] exp_rdata;
  string       test_name;

  logic [7:0]  shadow [mem_bytes];
  logic [31:0] lfsr_state = 32'h393e_eeca;

  data_mem_top #(
    .mem_bytes(mem_bytes)
  ) data_mem_top_inst (
    .clk, .rst,
    .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // ########################################
  // Failure reporting
  // ########################################

  task automatic fail_run();
    $display("Finished with errors");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("ERR %s: %s expected %h actual %h", test_name, what, expected, actual);
    fail_run();
  endtask

  // ########################################
  // Stimulus and reference model
  // ########################################

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value      = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return value;
  endfunction

  function automatic logic [10:0] make_addr(input access_width_e width, input logic sign_ext,
                                            input logic [7:0] byte_addr);
    return {sign_ext, width, byte_addr};
  endfunction

  function automatic logic access_error(input logic [10:0] addr);
    case (access_width_e'(addr[9:8]))
      byte_access: return 1'b0;
      half_access: return addr[0];
      word_access: return addr[1:0] != 2'b00;
      default:     return 1'b1;
    endcase
  endfunction

  function automatic logic [31:0] expected_load(input logic [10:0] addr);
    logic [7:0]  a;
    logic [15:0] half;
    a = addr[7:0];
    case (access_width_e'(addr[9:8]))
      byte_access: return addr[10] ? {{24{shadow[a][7]}}, shadow[a]} : {24'h0, shadow[a]};
      half_access: begin
        half = {shadow[8'(a + 1)], shadow[a]};
        return addr[10] ? {{16{half[15]}}, half} : {16'h0, half};
      end
      word_access: return {shadow[8'(a + 3)], shadow[8'(a + 2)], shadow[8'(a + 1)], shadow[a]};
      default:     return 32'h0;
    endcase
  endfunction

  task automatic store_shadow(input logic [10:0] addr, input logic [31:0] data);
    logic [7:0] a;
    a = addr[7:0];
    case (access_width_e'(addr[9:8]))
      byte_access: shadow[a] = data[7:0];
      half_access: begin
        shadow[a]          = data[7:0];
        shadow[8'(a + 1)]  = data[15:8];
      end
      default: begin
        for (int i = 0; i < 4; i++) begin
          shadow[8'(a + i)] = data[8*i +: 8];
        end
      end
    endcase
  endtask

  // One APB transfer with an idle cycle after it
  task automatic apb_transfer(input logic write, input logic [10:0] addr, input logic [31:0] data);
    logic err;
    err = access_error(addr);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable         <= 1'b1;
    first_cycle     <= 1'b1;
    exp_err         <= err;
    exp_first_ready <= write || err;
    exp_rdata       <= expected_load(addr);
    @(negedge clk);
    while (!pready) begin
      @(posedge clk);
      first_cycle <= 1'b0;
      @(negedge clk);
    end
    @(posedge clk);
    first_cycle <= 1'b0;
    psel        <= 1'b0;
    penable     <= 1'b0;
    if (write && !err) begin
      store_shadow(addr, data);
    end
  endtask

  // ########################################
  // Checks
  // ########################################

  assert property (@(posedge clk) disable iff (rst) !(psel && penable) |-> !pready && !pslverr)
    else report_mismatch("idle pready and pslverr", 32'h0, {$sampled(pready), $sampled(pslverr)});

  assert property (@(posedge clk) disable iff (rst) first_cycle |-> pready == exp_first_ready)
    else report_mismatch("first cycle pready", $sampled(exp_first_ready), $sampled(pready));

  assert property (@(posedge clk) disable iff (rst) first_cycle |-> pslverr == exp_err)
    else report_mismatch("first cycle pslverr", $sampled(exp_err), $sampled(pslverr));

  assert property (@(posedge clk) disable iff (rst) first_cycle && exp_err |-> prdata == 32'h0)
    else report_mismatch("error prdata", 32'h0, $sampled(prdata));

  // Read wait state ends one cycle later without error
  assert property (@(posedge clk) disable iff (rst)
                   first_cycle && !exp_first_ready |=> pready && !pslverr)
    else report_mismatch("read second cycle", 32'h2, {$sampled(pready), $sampled(pslverr)});

  assert property (@(posedge clk) disable iff (rst)
                   psel && penable && pready && !pwrite && !pslverr |-> prdata == exp_rdata)
    else report_mismatch("load data", $sampled(exp_rdata), $sampled(prdata));

  // ########################################
  // Test sequence
  // ########################################

  initial begin
    logic        rnd_write;
    logic [10:0] rnd_addr;
    logic [31:0] rnd_data;
    rst             = 1'b1;
    psel            = 1'b0;
    penable         = 1'b0;
    pwrite          = 1'b0;
    paddr           = '0;
    pwdata          = '0;
    first_cycle     = 1'b0;
    exp_err         = 1'b0;
    exp_first_ready = 1'b0;
    exp_rdata       = '0;
    test_name       = "reset";
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    // Idle cycles before the first transfer
    repeat (3) @(posedge clk);

    test_name = "fill";
    for (int w = 0; w < mem_bytes / 4; w++) begin
      apb_transfer(1'b1, make_addr(word_access, 1'b0, 8'(w * 4)), take_bits(32));
    end

    test_name = "word write and read";
    apb_transfer(1'b1, make_addr(word_access, 1'b0, 8'h40), 32'hdead_beef);
    apb_transfer(1'b0, make_addr(word_access, 1'b0, 8'h40), 32'h0);

    test_name = "sub-word stores";
    apb_transfer(1'b1, make_addr(byte_access, 1'b0, 8'h41), 32'hffff_ff5a);
    apb_transfer(1'b1, make_addr(half_access, 1'b0, 8'h46), 32'hffff_1234);
    apb_transfer(1'b0, make_addr(word_access, 1'b0, 8'h40), 32'h0);
    apb_transfer(1'b0, make_addr(word_access, 1'b0, 8'h44), 32'h0);

    test_name = "sub-word loads";
    // Every byte and half of this word has its top bit set
    apb_transfer(1'b1, make_addr(word_access, 1'b0, 8'h48), 32'hf1e2_d3c4);
    for (int off = 0; off < 4; off++) begin
      apb_transfer(1'b0, make_addr(byte_access, 1'b1, 8'(8'h48 + off)), 32'h0);
      apb_transfer(1'b0, make_addr(byte_access, 1'b0, 8'(8'h48 + off)), 32'h0);
    end
    for (int off = 0; off < 4; off += 2) begin
      apb_transfer(1'b0, make_addr(half_access, 1'b1, 8'(8'h48 + off)), 32'h0);
      apb_transfer(1'b0, make_addr(half_access, 1'b0, 8'(8'h48 + off)), 32'h0);
    end

    test_name = "misaligned";
    for (int dir = 0; dir < 2; dir++) begin
      apb_transfer(dir[0], make_addr(half_access, 1'b0, 8'h41), 32'h0bad_0bad);
      apb_transfer(dir[0], make_addr(word_access, 1'b0, 8'h42), 32'h0bad_0bad);
      apb_transfer(dir[0], make_addr(word_access, 1'b0, 8'h43), 32'h0bad_0bad);
      apb_transfer(dir[0], make_addr(reserved_access, 1'b0, 8'h40), 32'h0bad_0bad);
    end
    apb_transfer(1'b0, make_addr(word_access, 1'b0, 8'h40), 32'h0);
    apb_transfer(1'b0, make_addr(word_access, 1'b0, 8'h44), 32'h0);

    test_name = "random mix";
    repeat (random_count) begin
      rnd_write = take_bits(1);
      rnd_addr  = take_bits(11);
      rnd_data  = take_bits(32);
      apb_transfer(rnd_write, rnd_addr, rnd_data);
    end

    repeat (2) @(posedge clk);
    $display("Finished with no errors");
    $finish;
  end

  // At most four cycles per transfer, plus reset and idle time
  initial begin
    #(clk_period * (4 * transfer_total + 20));
    $display("Timeout: the transfers did not finish in the expected time");
    fail_run();
  end

endmodule
